/* include/standby_macros.svh */
// Width and lane-count macros for the standby TTI front end, included by RTL and testbench
`ifndef STANDBY_MACROS_SVH
`define STANDBY_MACROS_SVH

// Queue data byte
`define BYTE_W 8

// I2C engine TTI word
`define WORD_W 32

// Bytes per I2C word and the width of a byte index
`define LANES 4
`define LANE_W 2

// RX descriptor
`define DESC_W 32

// Received address including the RnW bit
`define ADDR_W 8

`endif

/* design/standby_pkg.sv */
// Shared types of the standby TTI front end, referenced by scoped name from RTL and testbench
`include "standby_macros.svh"

package standby_pkg;

  // One entry of the RX or TX data queue
  typedef logic [`BYTE_W-1:0] tti_byte_t;

  // I2C word, seen whole by the engine and per lane by the converters
  // Lane 0 sits in the low bits
  typedef union packed {
    logic [`WORD_W-1:0] word;
    tti_byte_t [`LANES-1:0] lanes;
  } tti_word_u;

  // Active protocol engine
  typedef enum logic {
    BUS_I2C = 1'b0,
    BUS_I3C = 1'b1
  } bus_mode_e;

endpackage

/* design/tti_mode_ctrl.sv */
// Mode select and queue routing between the I2C and I3C engines, with the sticky error flag
`timescale 1ns/1ps
`include "standby_macros.svh"

module tti_mode_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i3c_active_en_i,
  input  logic                   i3c_standby_en_i,
  input  logic                   parity_err_i,
  input  logic                   get_status_done_i,
  // I3C engine
  input  logic                   i3c_rx_desc_valid_i,
  input  logic                   i3c_rx_valid_i,
  input  logic [`DESC_W-1:0]     i3c_rx_desc_data_i,
  input  standby_pkg::tti_byte_t i3c_rx_data_i,
  input  logic                   i3c_tx_desc_ready_i,
  input  logic                   i3c_tx_ready_i,
  input  logic                   i3c_tx_flush_i,
  input  logic                   i3c_ibi_ready_i,
  input  logic                   i3c_start_i,
  input  logic                   i3c_rstart_i,
  input  logic                   i3c_stop_i,
  input  logic [`ADDR_W-1:0]     i3c_addr_i,
  input  logic                   i3c_addr_valid_i,
  // I2C engine
  input  logic                   i2c_rx_desc_valid_i,
  input  logic [`DESC_W-1:0]     i2c_rx_desc_data_i,
  input  logic                   i2c_tx_desc_ready_i,
  input  logic                   i2c_start_i,
  input  logic                   i2c_rstart_i,
  input  logic                   i2c_stop_i,
  input  logic [`ADDR_W-1:0]     i2c_addr_i,
  input  logic                   i2c_addr_valid_i,
  // Width converters
  input  logic                   conv_rx_valid_i,
  input  standby_pkg::tti_byte_t conv_rx_data_i,
  input  logic                   conv_tx_ready_i,
  // Queues
  input  logic                   rx_queue_wready_i,
  input  logic                   tx_queue_rvalid_i,
  input  logic                   ibi_queue_rvalid_i,
  input  logic                   ibi_queue_full_i,
  input  logic                   ibi_queue_empty_i,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [`DESC_W-1:0]     rx_desc_queue_wdata_o,
  output logic                   rx_queue_wvalid_o,
  output standby_pkg::tti_byte_t rx_queue_wdata_o,
  output logic                   tx_desc_queue_rready_o,
  output logic                   tx_queue_rready_o,
  output logic                   tx_queue_flush_o,
  output logic                   ibi_queue_rready_o,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output logic [`ADDR_W-1:0]     bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   conv_rx_ready_o,
  output logic                   conv_tx_valid_o,
  output logic                   i3c_ibi_rvalid_o,
  output logic                   i3c_ibi_full_o,
  output logic                   i3c_ibi_empty_o,
  output logic                   err_o
);

  standby_pkg::bus_mode_e mode;
  logic                   i3c_sel;

  // Any I3C enable hands the queues to the I3C engine
  assign mode = (i3c_active_en_i | i3c_standby_en_i) ? standby_pkg::BUS_I3C
                                                     : standby_pkg::BUS_I2C;
  assign i3c_sel = (mode == standby_pkg::BUS_I3C);

  always_comb begin
    rx_desc_queue_wvalid_o = i3c_sel ? i3c_rx_desc_valid_i : i2c_rx_desc_valid_i;
    rx_desc_queue_wdata_o  = i3c_sel ? i3c_rx_desc_data_i : i2c_rx_desc_data_i;
    // I2C data arrives through the word-to-byte converter
    rx_queue_wvalid_o      = i3c_sel ? i3c_rx_valid_i : conv_rx_valid_i;
    rx_queue_wdata_o       = i3c_sel ? i3c_rx_data_i : conv_rx_data_i;
    tx_desc_queue_rready_o = i3c_sel ? i3c_tx_desc_ready_i : i2c_tx_desc_ready_i;
    tx_queue_rready_o      = i3c_sel ? i3c_tx_ready_i : conv_tx_ready_i;
    tx_queue_flush_o       = i3c_sel ? i3c_tx_flush_i : 1'b0;

    bus_start_o      = i3c_sel ? i3c_start_i : i2c_start_i;
    bus_rstart_o     = i3c_sel ? i3c_rstart_i : i2c_rstart_i;
    bus_stop_o       = i3c_sel ? i3c_stop_i : i2c_stop_i;
    bus_addr_o       = i3c_sel ? i3c_addr_i : i2c_addr_i;
    bus_addr_valid_o = i3c_sel ? i3c_addr_valid_i : i2c_addr_valid_i;

    // IBI queue is invisible to the I3C engine in I2C mode
    i3c_ibi_rvalid_o   = i3c_sel ? ibi_queue_rvalid_i : 1'b0;
    i3c_ibi_full_o     = i3c_sel ? ibi_queue_full_i : 1'b0;
    i3c_ibi_empty_o    = i3c_sel ? ibi_queue_empty_i : 1'b0;
    ibi_queue_rready_o = i3c_sel ? i3c_ibi_ready_i : 1'b0;

    conv_rx_ready_o = rx_queue_wready_i;
    // Keep TX bytes out of the packer while I3C owns the queue
    conv_tx_valid_o = i3c_sel ? 1'b0 : tx_queue_rvalid_i;
  end

  // Sticky until GET STATUS completes, clear has priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o <= 1'b0;
    end else if (get_status_done_i) begin
      err_o <= 1'b0;
    end else if (parity_err_i) begin
      err_o <= 1'b1;
    end
  end

endmodule

/* design/rx_word_to_byte.sv */
// Splits I2C RX words into bytes for the RX data queue, lane 0 first
`timescale 1ns/1ps
`include "standby_macros.svh"

module rx_word_to_byte (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   word_valid_i,
  output logic                   word_ready_o,
  input  standby_pkg::tti_word_u word_data_i,
  output logic                   byte_valid_o,
  input  logic                   byte_ready_i,
  output standby_pkg::tti_byte_t byte_data_o
);

  standby_pkg::tti_word_u word_q;
  logic [`LANE_W-1:0]     lane_q;
  logic                   full_q;
  logic                   word_take;
  logic                   byte_take;
  logic                   last_lane;

  // Only an empty buffer accepts a word
  assign word_ready_o = ~full_q;
  assign word_take    = word_valid_i & ~full_q;

  assign byte_valid_o = full_q;
  assign byte_data_o  = word_q.lanes[lane_q];
  assign byte_take    = full_q & byte_ready_i;
  assign last_lane    = (lane_q == `LANE_W'(`LANES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (word_take) begin
      full_q <= 1'b1;
      lane_q <= '0;
    end else if (byte_take) begin
      if (last_lane) begin
        full_q <= 1'b0;
        lane_q <= '0;
      end else begin
        lane_q <= lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (word_take) begin
      word_q <= word_data_i;
    end
  end

endmodule

/* design/tx_byte_to_word.sv */
// Packs TX data queue bytes into I2C words, first byte in lane 0
`timescale 1ns/1ps
`include "standby_macros.svh"

module tx_byte_to_word (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   byte_valid_i,
  output logic                   byte_ready_o,
  input  standby_pkg::tti_byte_t byte_data_i,
  output logic                   word_valid_o,
  input  logic                   word_ready_i,
  output standby_pkg::tti_word_u word_data_o
);

  standby_pkg::tti_word_u word_q;
  logic [`LANE_W-1:0]     lane_q;
  logic                   full_q;
  logic                   byte_take;
  logic                   word_take;
  logic                   last_lane;

  // Intake stalls while a complete word waits for the engine
  assign byte_ready_o = ~full_q;
  assign byte_take    = byte_valid_i & ~full_q;

  assign word_valid_o = full_q;
  assign word_data_o  = word_q;
  assign word_take    = full_q & word_ready_i;
  assign last_lane    = (lane_q == `LANE_W'(`LANES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (byte_take) begin
      if (last_lane) begin
        full_q <= 1'b1;
        lane_q <= '0;
      end else begin
        lane_q <= lane_q + 1'b1;
      end
    end else if (word_take) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (byte_take) begin
      word_q.lanes[lane_q] <= byte_data_i;
    end
  end

endmodule

/* design/controller_standby.sv */
// Standby target TTI front end top, joins mode control and the I2C width converters
`timescale 1ns/1ps
`include "standby_macros.svh"

module controller_standby (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i3c_active_en_i,
  input  logic                   i3c_standby_en_i,
  input  logic                   parity_err_i,
  input  logic                   get_status_done_i,
  // I3C engine
  input  logic                   i3c_rx_desc_valid_i,
  input  logic                   i3c_rx_valid_i,
  input  logic [`DESC_W-1:0]     i3c_rx_desc_data_i,
  input  standby_pkg::tti_byte_t i3c_rx_data_i,
  input  logic                   i3c_tx_desc_ready_i,
  input  logic                   i3c_tx_ready_i,
  input  logic                   i3c_tx_flush_i,
  input  logic                   i3c_ibi_ready_i,
  input  logic                   i3c_start_i,
  input  logic                   i3c_rstart_i,
  input  logic                   i3c_stop_i,
  input  logic [`ADDR_W-1:0]     i3c_addr_i,
  input  logic                   i3c_addr_valid_i,
  output standby_pkg::tti_byte_t i3c_tx_data_o,
  output logic                   i3c_ibi_rvalid_o,
  output logic                   i3c_ibi_full_o,
  output logic                   i3c_ibi_empty_o,
  // I2C engine
  input  logic                   i2c_rx_desc_valid_i,
  input  logic [`DESC_W-1:0]     i2c_rx_desc_data_i,
  input  logic                   i2c_tx_desc_ready_i,
  input  logic                   i2c_start_i,
  input  logic                   i2c_rstart_i,
  input  logic                   i2c_stop_i,
  input  logic [`ADDR_W-1:0]     i2c_addr_i,
  input  logic                   i2c_addr_valid_i,
  input  logic                   i2c_rx_valid_i,
  output logic                   i2c_rx_ready_o,
  input  standby_pkg::tti_word_u i2c_rx_data_i,
  output logic                   i2c_tx_valid_o,
  input  logic                   i2c_tx_ready_i,
  output standby_pkg::tti_word_u i2c_tx_data_o,
  // Queues
  input  logic                   rx_queue_wready_i,
  input  logic                   tx_queue_rvalid_i,
  input  standby_pkg::tti_byte_t tx_queue_rdata_i,
  input  logic                   ibi_queue_rvalid_i,
  input  logic                   ibi_queue_full_i,
  input  logic                   ibi_queue_empty_i,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [`DESC_W-1:0]     rx_desc_queue_wdata_o,
  output logic                   rx_queue_wvalid_o,
  output standby_pkg::tti_byte_t rx_queue_wdata_o,
  output logic                   tx_desc_queue_rready_o,
  output logic                   tx_queue_rready_o,
  output logic                   tx_queue_flush_o,
  output logic                   ibi_queue_rready_o,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output logic [`ADDR_W-1:0]     bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   err_o
);

  // Byte side of the converters
  logic                   conv_rx_valid;
  logic                   conv_rx_ready;
  standby_pkg::tti_byte_t conv_rx_data;
  logic                   conv_tx_valid;
  logic                   conv_tx_ready;

  // I3C engine reads TX bytes straight from the queue
  assign i3c_tx_data_o = tx_queue_rdata_i;

  tti_mode_ctrl u_mode_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .i3c_active_en_i        (i3c_active_en_i),
    .i3c_standby_en_i       (i3c_standby_en_i),
    .parity_err_i           (parity_err_i),
    .get_status_done_i      (get_status_done_i),
    .i3c_rx_desc_valid_i    (i3c_rx_desc_valid_i),
    .i3c_rx_valid_i         (i3c_rx_valid_i),
    .i3c_rx_desc_data_i     (i3c_rx_desc_data_i),
    .i3c_rx_data_i          (i3c_rx_data_i),
    .i3c_tx_desc_ready_i    (i3c_tx_desc_ready_i),
    .i3c_tx_ready_i         (i3c_tx_ready_i),
    .i3c_tx_flush_i         (i3c_tx_flush_i),
    .i3c_ibi_ready_i        (i3c_ibi_ready_i),
    .i3c_start_i            (i3c_start_i),
    .i3c_rstart_i           (i3c_rstart_i),
    .i3c_stop_i             (i3c_stop_i),
    .i3c_addr_i             (i3c_addr_i),
    .i3c_addr_valid_i       (i3c_addr_valid_i),
    .i2c_rx_desc_valid_i    (i2c_rx_desc_valid_i),
    .i2c_rx_desc_data_i     (i2c_rx_desc_data_i),
    .i2c_tx_desc_ready_i    (i2c_tx_desc_ready_i),
    .i2c_start_i            (i2c_start_i),
    .i2c_rstart_i           (i2c_rstart_i),
    .i2c_stop_i             (i2c_stop_i),
    .i2c_addr_i             (i2c_addr_i),
    .i2c_addr_valid_i       (i2c_addr_valid_i),
    .conv_rx_valid_i        (conv_rx_valid),
    .conv_rx_data_i         (conv_rx_data),
    .conv_tx_ready_i        (conv_tx_ready),
    .rx_queue_wready_i      (rx_queue_wready_i),
    .tx_queue_rvalid_i      (tx_queue_rvalid_i),
    .ibi_queue_rvalid_i     (ibi_queue_rvalid_i),
    .ibi_queue_full_i       (ibi_queue_full_i),
    .ibi_queue_empty_i      (ibi_queue_empty_i),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .tx_desc_queue_rready_o (tx_desc_queue_rready_o),
    .tx_queue_rready_o      (tx_queue_rready_o),
    .tx_queue_flush_o       (tx_queue_flush_o),
    .ibi_queue_rready_o     (ibi_queue_rready_o),
    .bus_start_o            (bus_start_o),
    .bus_rstart_o           (bus_rstart_o),
    .bus_stop_o             (bus_stop_o),
    .bus_addr_o             (bus_addr_o),
    .bus_addr_valid_o       (bus_addr_valid_o),
    .conv_rx_ready_o        (conv_rx_ready),
    .conv_tx_valid_o        (conv_tx_valid),
    .i3c_ibi_rvalid_o       (i3c_ibi_rvalid_o),
    .i3c_ibi_full_o         (i3c_ibi_full_o),
    .i3c_ibi_empty_o        (i3c_ibi_empty_o),
    .err_o                  (err_o)
  );

  // 32 to 8 on the RX data path
  rx_word_to_byte u_rx_conv (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (i2c_rx_valid_i),
    .word_ready_o (i2c_rx_ready_o),
    .word_data_i  (i2c_rx_data_i),
    .byte_valid_o (conv_rx_valid),
    .byte_ready_i (conv_rx_ready),
    .byte_data_o  (conv_rx_data)
  );

  // 8 to 32 on the TX data path
  tx_byte_to_word u_tx_conv (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .byte_valid_i (conv_tx_valid),
    .byte_ready_o (conv_tx_ready),
    .byte_data_i  (tx_queue_rdata_i),
    .word_valid_o (i2c_tx_valid_o),
    .word_ready_i (i2c_tx_ready_i),
    .word_data_o  (i2c_tx_data_o)
  );

endmodule

/* test/tb_controller_standby.sv */
// Table-driven testbench for the standby TTI front end and simulation top of src.f
`timescale 1ns/1ps
`include "standby_macros.svh"

module tb_controller_standby;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_ROWS       = 18;
  localparam int MAX_ROW_CYCLES = 64;

  localparam int K_ROUTE = 0;
  localparam int K_RX    = 1;
  localparam int K_TX    = 2;
  localparam int K_IBI   = 3;
  localparam int K_ERR   = 4;

  logic clk_i;
  logic rst_ni;
  logic i3c_active_en_i, i3c_standby_en_i;
  logic parity_err_i, get_status_done_i;
  logic i3c_rx_desc_valid_i, i3c_rx_valid_i, i2c_rx_desc_valid_i;
  logic [`DESC_W-1:0] i3c_rx_desc_data_i, i2c_rx_desc_data_i;
  standby_pkg::tti_byte_t i3c_rx_data_i, tx_queue_rdata_i;
  logic i3c_tx_desc_ready_i, i3c_tx_ready_i, i3c_tx_flush_i, i3c_ibi_ready_i;
  logic i3c_start_i, i3c_rstart_i, i3c_stop_i;
  logic i2c_start_i, i2c_rstart_i, i2c_stop_i;
  logic [`ADDR_W-1:0] i3c_addr_i, i2c_addr_i;
  logic i3c_addr_valid_i, i2c_addr_valid_i, i2c_tx_desc_ready_i;
  logic i2c_rx_valid_i, i2c_tx_ready_i;
  standby_pkg::tti_word_u i2c_rx_data_i;
  logic rx_queue_wready_i, tx_queue_rvalid_i;
  logic ibi_queue_rvalid_i, ibi_queue_full_i, ibi_queue_empty_i;
  // DUT outputs
  standby_pkg::tti_byte_t i3c_tx_data_o, rx_queue_wdata_o;
  logic i3c_ibi_rvalid_o, i3c_ibi_full_o, i3c_ibi_empty_o;
  logic i2c_rx_ready_o, i2c_tx_valid_o;
  standby_pkg::tti_word_u i2c_tx_data_o;
  logic rx_desc_queue_wvalid_o, rx_queue_wvalid_o;
  logic [`DESC_W-1:0] rx_desc_queue_wdata_o;
  logic tx_desc_queue_rready_o, tx_queue_rready_o, tx_queue_flush_o, ibi_queue_rready_o;
  logic bus_start_o, bus_rstart_o, bus_stop_o, bus_addr_valid_o;
  logic [`ADDR_W-1:0] bus_addr_o;
  logic err_o;

  // Scenario table
  string                  row_name [NUM_ROWS];
  int                     row_kind [NUM_ROWS];
  standby_pkg::bus_mode_e row_mode [NUM_ROWS];
  standby_pkg::tti_word_u row_word [NUM_ROWS];
  logic [15:0]            row_rdy  [NUM_ROWS];
  logic                   row_flag [NUM_ROWS];
  int                     row_count;
  int                     seed;

  controller_standby dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_and_stop();
    $display("Some tests failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_byte(input string name, input standby_pkg::tti_byte_t exp,
                            input standby_pkg::tti_byte_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      fail_and_stop();
    end
  endtask

  task automatic check_word(input string name, input standby_pkg::tti_word_u exp,
                            input standby_pkg::tti_word_u act);
    if (act.word !== exp.word) begin
      $display("** Error %s: expected %h, actual %h", name, exp.word, act.word);
      fail_and_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      fail_and_stop();
    end
  endtask

  // Byte k of a word with lane 0 in the low bits
  function automatic standby_pkg::tti_byte_t lane_of(input standby_pkg::tti_word_u w,
                                                     input int k);
    logic [`WORD_W-1:0] shifted;
    shifted = w.word >> (k * `BYTE_W);
    return shifted[`BYTE_W-1:0];
  endfunction

  task automatic add_row(input string name, input int kind, input standby_pkg::bus_mode_e mode,
                         input logic [`WORD_W-1:0] word, input logic [15:0] rdy,
                         input logic flag);
    row_name[row_count]      = name;
    row_kind[row_count]      = kind;
    row_mode[row_count]      = mode;
    row_word[row_count].word = word;
    row_rdy[row_count]       = rdy;
    row_flag[row_count]      = flag;
    row_count++;
  endtask

  // RX ready pattern 0 means random
  // TX rows use it as the stall count
  task automatic build_table();
    add_row("route_i3c_standby", K_ROUTE, standby_pkg::BUS_I3C, 32'hA5C3_1E07, 16'h0, 1'b0);
    add_row("route_i2c", K_ROUTE, standby_pkg::BUS_I2C, 32'h5AF0_0C3D, 16'h0, 1'b0);
    add_row("route_i3c_active", K_ROUTE, standby_pkg::BUS_I3C, 32'h0BAD_F00C, 16'h0, 1'b0);
    add_row("rx_split_ready", K_RX, standby_pkg::BUS_I2C, 32'h4433_2211, 16'hFFFF, 1'b0);
    add_row("rx_split_stall", K_RX, standby_pkg::BUS_I2C, 32'hDEAD_BEEF, 16'h5A35, 1'b0);
    add_row("rx_split_rand_a", K_RX, standby_pkg::BUS_I2C, $random(seed), 16'h0, 1'b0);
    add_row("rx_split_rand_b", K_RX, standby_pkg::BUS_I2C, $random(seed), 16'h0, 1'b0);
    add_row("tx_pack", K_TX, standby_pkg::BUS_I2C, 32'h8877_6655, 16'd2, 1'b0);
    add_row("tx_pack_rand", K_TX, standby_pkg::BUS_I2C, $random(seed), 16'd0, 1'b0);
    add_row("ibi_i2c_gated", K_IBI, standby_pkg::BUS_I2C, 32'h3, 16'h0, 1'b0);
    add_row("ibi_i3c_active", K_IBI, standby_pkg::BUS_I3C, 32'h1, 16'h0, 1'b0);
    add_row("ibi_i3c_standby", K_IBI, standby_pkg::BUS_I3C, 32'h2, 16'h0, 1'b0);
    add_row("err_set", K_ERR, standby_pkg::BUS_I2C, 32'h1, 16'h0, 1'b1);
    add_row("err_hold", K_ERR, standby_pkg::BUS_I2C, 32'h0, 16'h0, 1'b1);
    add_row("err_clear", K_ERR, standby_pkg::BUS_I2C, 32'h2, 16'h0, 1'b0);
    add_row("err_set_again", K_ERR, standby_pkg::BUS_I2C, 32'h1, 16'h0, 1'b1);
    add_row("err_clear_wins", K_ERR, standby_pkg::BUS_I2C, 32'h3, 16'h0, 1'b0);
    add_row("err_idle", K_ERR, standby_pkg::BUS_I2C, 32'h0, 16'h0, 1'b0);
  endtask

  task automatic clear_inputs();
    i3c_active_en_i     <= 1'b0;
    i3c_standby_en_i    <= 1'b0;
    parity_err_i        <= 1'b0;
    get_status_done_i   <= 1'b0;
    i3c_rx_desc_valid_i <= 1'b0;
    i3c_rx_valid_i      <= 1'b0;
    i3c_rx_desc_data_i  <= '0;
    i3c_rx_data_i       <= '0;
    i3c_tx_desc_ready_i <= 1'b0;
    i3c_tx_ready_i      <= 1'b0;
    i3c_tx_flush_i      <= 1'b0;
    i3c_ibi_ready_i     <= 1'b0;
    i3c_start_i         <= 1'b0;
    i3c_rstart_i        <= 1'b0;
    i3c_stop_i          <= 1'b0;
    i3c_addr_i          <= '0;
    i3c_addr_valid_i    <= 1'b0;
    i2c_rx_desc_valid_i <= 1'b0;
    i2c_rx_desc_data_i  <= '0;
    i2c_tx_desc_ready_i <= 1'b0;
    i2c_start_i         <= 1'b0;
    i2c_rstart_i        <= 1'b0;
    i2c_stop_i          <= 1'b0;
    i2c_addr_i          <= '0;
    i2c_addr_valid_i    <= 1'b0;
    i2c_rx_valid_i      <= 1'b0;
    i2c_rx_data_i       <= '0;
    i2c_tx_ready_i      <= 1'b0;
    rx_queue_wready_i   <= 1'b0;
    tx_queue_rvalid_i   <= 1'b0;
    tx_queue_rdata_i    <= '0;
    ibi_queue_rvalid_i  <= 1'b0;
    ibi_queue_full_i    <= 1'b0;
    ibi_queue_empty_i   <= 1'b0;
  endtask

  task automatic select_mode(input standby_pkg::bus_mode_e mode, input logic use_standby);
    i3c_active_en_i  <= (mode == standby_pkg::BUS_I3C) && !use_standby;
    i3c_standby_en_i <= (mode == standby_pkg::BUS_I3C) && use_standby;
  endtask

  task automatic route_events(input int r);
    standby_pkg::tti_word_u w;
    standby_pkg::tti_word_u desc;
    logic                   sel;
    w   = row_word[r];
    sel = (row_mode[r] == standby_pkg::BUS_I3C);
    // Idle engine drives the inverse so a wrong select shows up
    i3c_rx_desc_valid_i <= sel;
    i2c_rx_desc_valid_i <= !sel;
    i3c_rx_desc_data_i  <= sel ? w.word : ~w.word;
    i2c_rx_desc_data_i  <= sel ? ~w.word : w.word;
    i3c_rx_valid_i      <= sel;
    i3c_rx_data_i       <= lane_of(w, 0);
    i3c_tx_desc_ready_i <= sel;
    i2c_tx_desc_ready_i <= !sel;
    i3c_addr_i          <= sel ? lane_of(w, 1) : ~lane_of(w, 1);
    i2c_addr_i          <= sel ? ~lane_of(w, 1) : lane_of(w, 1);
    i3c_addr_valid_i    <= sel;
    i2c_addr_valid_i    <= !sel;
    for (int ev = 0; ev < 3; ev++) begin
      if (ev > 0) begin
        @(posedge clk_i);
      end
      i3c_start_i  <= sel ? (ev == 0) : (ev != 0);
      i3c_rstart_i <= sel ? (ev == 1) : (ev != 1);
      i3c_stop_i   <= sel ? (ev == 2) : (ev != 2);
      i2c_start_i  <= sel ? (ev != 0) : (ev == 0);
      i2c_rstart_i <= sel ? (ev != 1) : (ev == 1);
      i2c_stop_i   <= sel ? (ev != 2) : (ev == 2);
      // Idle packer is ready, so a low I3C ready shows the select
      i3c_tx_ready_i <= (ev == 1);
      @(negedge clk_i);
      desc.word = rx_desc_queue_wdata_o;
      check_flag({row_name[r], " start"}, ev == 0, bus_start_o);
      check_flag({row_name[r], " rstart"}, ev == 1, bus_rstart_o);
      check_flag({row_name[r], " stop"}, ev == 2, bus_stop_o);
      check_flag({row_name[r], " desc valid"}, 1'b1, rx_desc_queue_wvalid_o);
      check_word({row_name[r], " desc data"}, w, desc);
      check_flag({row_name[r], " tx desc ready"}, 1'b1, tx_desc_queue_rready_o);
      check_byte({row_name[r], " addr"}, lane_of(w, 1), bus_addr_o);
      check_flag({row_name[r], " addr valid"}, 1'b1, bus_addr_valid_o);
      check_flag({row_name[r], " rx valid"}, sel, rx_queue_wvalid_o);
      if (sel) begin
        check_byte({row_name[r], " rx byte"}, lane_of(w, 0), rx_queue_wdata_o);
        check_flag({row_name[r], " tx ready"}, ev == 1, tx_queue_rready_o);
      end
    end
  endtask

  task automatic split_rx_word(input int r);
    standby_pkg::tti_word_u w;
    logic [31:0]            rnd;
    logic [3:0]             c;
    int                     k;
    w = row_word[r];
    c = '0;
    k = 0;
    i2c_rx_valid_i <= 1'b1;
    i2c_rx_data_i  <= w;
    @(negedge clk_i);
    while (!i2c_rx_ready_o) begin
      @(negedge clk_i);
    end
    // Word is taken on this edge
    @(posedge clk_i);
    i2c_rx_valid_i     <= 1'b0;
    i2c_rx_data_i.word <= ~w.word;
    while (k < `LANES) begin
      if (row_rdy[r] == '0) begin
        rnd = $random(seed);
        rx_queue_wready_i <= rnd[0];
      end else begin
        rx_queue_wready_i <= row_rdy[r][c];
      end
      c = c + 4'd1;
      @(negedge clk_i);
      check_flag({row_name[r], " byte valid"}, 1'b1, rx_queue_wvalid_o);
      check_byte({row_name[r], " byte"}, lane_of(w, k), rx_queue_wdata_o);
      if (rx_queue_wready_i) begin
        k++;
      end
      @(posedge clk_i);
    end
    rx_queue_wready_i <= 1'b0;
    @(negedge clk_i);
    check_flag({row_name[r], " word ready"}, 1'b1, i2c_rx_ready_o);
    check_flag({row_name[r], " byte valid after"}, 1'b0, rx_queue_wvalid_o);
  endtask

  task automatic pack_tx_bytes(input int r);
    standby_pkg::tti_word_u w;
    int                     k;
    w = row_word[r];
    k = 0;
    // I3C side pulls high to prove it is ignored in I2C mode
    i3c_tx_ready_i    <= 1'b1;
    i3c_tx_flush_i    <= 1'b1;
    tx_queue_rvalid_i <= 1'b1;
    tx_queue_rdata_i  <= lane_of(w, 0);
    @(negedge clk_i);
    while (k < `LANES) begin
      check_flag({row_name[r], " word valid early"}, 1'b0, i2c_tx_valid_o);
      check_flag({row_name[r], " flush"}, 1'b0, tx_queue_flush_o);
      if (tx_queue_rready_o) begin
        k++;
      end
      @(posedge clk_i);
      tx_queue_rvalid_i <= (k < `LANES);
      tx_queue_rdata_i  <= lane_of(w, k);
      @(negedge clk_i);
    end
    check_flag({row_name[r], " word valid"}, 1'b1, i2c_tx_valid_o);
    check_word({row_name[r], " word"}, w, i2c_tx_data_o);
    check_flag({row_name[r], " byte ready held"}, 1'b0, tx_queue_rready_o);
    repeat (row_rdy[r]) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_flag({row_name[r], " word valid stall"}, 1'b1, i2c_tx_valid_o);
      check_flag({row_name[r], " byte ready stall"}, 1'b0, tx_queue_rready_o);
    end
    @(posedge clk_i);
    i2c_tx_ready_i <= 1'b1;
    @(negedge clk_i);
    check_word({row_name[r], " word at take"}, w, i2c_tx_data_o);
    @(posedge clk_i);
    i2c_tx_ready_i <= 1'b0;
    @(negedge clk_i);
    check_flag({row_name[r], " word valid after"}, 1'b0, i2c_tx_valid_o);
    check_flag({row_name[r], " byte ready after"}, 1'b1, tx_queue_rready_o);
  endtask

  task automatic gate_ibi(input int r);
    standby_pkg::tti_word_u w;
    logic                   sel;
    w   = row_word[r];
    sel = (row_mode[r] == standby_pkg::BUS_I3C);
    ibi_queue_rvalid_i <= 1'b1;
    ibi_queue_full_i   <= w.word[0];
    ibi_queue_empty_i  <= w.word[1];
    i3c_ibi_ready_i    <= 1'b1;
    i3c_tx_flush_i     <= 1'b1;
    tx_queue_rdata_i   <= ~lane_of(w, 0);
    @(negedge clk_i);
    check_flag({row_name[r], " ibi valid"}, sel, i3c_ibi_rvalid_o);
    check_flag({row_name[r], " ibi full"}, sel & w.word[0], i3c_ibi_full_o);
    check_flag({row_name[r], " ibi empty"}, sel & w.word[1], i3c_ibi_empty_o);
    check_flag({row_name[r], " ibi ready"}, sel, ibi_queue_rready_o);
    check_flag({row_name[r], " tx flush"}, sel, tx_queue_flush_o);
    check_byte({row_name[r], " i3c tx byte"}, ~lane_of(w, 0), i3c_tx_data_o);
  endtask

  task automatic pulse_error(input int r);
    parity_err_i      <= row_word[r].word[0];
    get_status_done_i <= row_word[r].word[1];
    @(posedge clk_i);
    parity_err_i      <= 1'b0;
    get_status_done_i <= 1'b0;
    @(negedge clk_i);
    check_flag({row_name[r], " err"}, row_flag[r], err_o);
  endtask

  // Worst case per row bounds the whole run
  initial begin
    #((RESET_CYCLES + 4 + NUM_ROWS * MAX_ROW_CYCLES) * CLK_PERIOD);
    $display("Timeout: the table did not complete, a handshake never finished");
    fail_and_stop();
  end

  initial begin
    seed      = 34651;
    row_count = 0;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    clear_inputs();
    build_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("reset err", 1'b0, err_o);
    check_flag("reset rx word ready", 1'b1, i2c_rx_ready_o);
    check_flag("reset rx byte valid", 1'b0, rx_queue_wvalid_o);
    check_flag("reset tx word valid", 1'b0, i2c_tx_valid_o);
    check_flag("reset tx byte ready", 1'b1, tx_queue_rready_o);
    for (int r = 0; r < row_count; r++) begin
      @(posedge clk_i);
      clear_inputs();
      select_mode(row_mode[r], row_word[r].word[1]);
      case (row_kind[r])
        K_ROUTE: route_events(r);
        K_RX:    split_rx_word(r);
        K_TX:    pack_tx_bytes(r);
        K_IBI:   gate_ibi(r);
        K_ERR:   pulse_error(r);
        default: begin
          $display("Row %0d has an unknown kind %0d", r, row_kind[r]);
          fail_and_stop();
        end
      endcase
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
design/standby_pkg.sv
design/tti_mode_ctrl.sv
design/rx_word_to_byte.sv
design/tx_byte_to_word.sv
design/controller_standby.sv
test/tb_controller_standby.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_controller_standby
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
